/* Makefile */
# Verilator build and run for the Zcmp expander testbench

TOP := tb_zcmp_expander
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f zcmp_expander.f \
		--top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* hw/zcmp_expander.sv */
// Zcmp macro expander top; sits between fetch and issue, one word in at a time
`timescale 1ns/1ps
`default_nettype none
`include "zcmp_macros.svh"

module zcmp_expander (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // upstream
  input  logic [`ZCMP_ILEN-1:0] instr_i,
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  // downstream
  output logic [`ZCMP_ILEN-1:0] instr_o,
  output logic                  instr_valid_o,
  output logic                  illegal_o,
  output logic                  last_o,
  input  logic                  issue_ack_i
);
  import zcmp_pkg::*;

  macro_op_e              op;
  logic [`ZCMP_CNT_W-1:0] reg_cnt;
  logic [`ZCMP_IMM_W-1:0] stack_adj;
  logic [`ZCMP_REG_W-1:0] xreg1;
  logic [`ZCMP_REG_W-1:0] xreg2;
  logic                   illegal;
  uop_kind_e              uop_kind;
  logic [`ZCMP_REG_W-1:0] uop_rd;
  logic [`ZCMP_REG_W-1:0] uop_rs;
  logic [`ZCMP_IMM_W-1:0] uop_imm;

  zcmp_field_decode u_decode (
    .instr_i     (instr_i),
    .op_o        (op),
    .reg_cnt_o   (reg_cnt),
    .stack_adj_o (stack_adj),
    .xreg1_o     (xreg1),
    .xreg2_o     (xreg2),
    .illegal_o   (illegal)
  );

  zcmp_seq_fsm u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .issue_ack_i   (issue_ack_i),
    .op_i          (op),
    .reg_cnt_i     (reg_cnt),
    .stack_adj_i   (stack_adj),
    .xreg1_i       (xreg1),
    .xreg2_i       (xreg2),
    .illegal_i     (illegal),
    .uop_kind_o    (uop_kind),
    .uop_rd_o      (uop_rd),
    .uop_rs_o      (uop_rs),
    .uop_imm_o     (uop_imm),
    .instr_valid_o (instr_valid_o),
    .instr_ready_o (instr_ready_o),
    .last_o        (last_o),
    .illegal_o     (illegal_o)
  );

  zcmp_uop_encode u_encode (
    .instr_i    (instr_i),
    .uop_kind_i (uop_kind),
    .uop_rd_i   (uop_rd),
    .uop_rs_i   (uop_rs),
    .uop_imm_i  (uop_imm),
    .op_i       (op),
    .instr_o    (instr_o)
  );

endmodule

`default_nettype wire

/* hw/zcmp_field_decode.sv */
// combinational Zcmp classifier; feeds macro type and fields to the sequencer
`timescale 1ns/1ps
`default_nettype none
`include "zcmp_macros.svh"

module zcmp_field_decode (
  input  logic [`ZCMP_ILEN-1:0]  instr_i,
  output zcmp_pkg::macro_op_e    op_o,
  output logic [`ZCMP_CNT_W-1:0] reg_cnt_o,
  output logic [`ZCMP_IMM_W-1:0] stack_adj_o,
  output logic [`ZCMP_REG_W-1:0] xreg1_o,
  output logic [`ZCMP_REG_W-1:0] xreg2_o,
  output logic                   illegal_o
);
  import zcmp_pkg::*;

  localparam logic [`ZCMP_IMM_W-1:0] ALIGN_MASK = `ZCMP_IMM_W'(`ZCMP_STACK_ALIGN - 1);

  logic                   zcmp_space;
  logic [3:0]             rlist;
  logic [1:0]             spimm;
  logic [2:0]             r1s;
  logic [2:0]             r2s;
  logic [`ZCMP_CNT_W-1:0] n_regs;
  logic [`ZCMP_IMM_W-1:0] list_bytes;
  macro_op_e              op_raw;
  logic                   bad;

  // sreg field: 0,1 -> s0,s1 (x8,x9); 2..7 -> s2..s7 (x18..x23)
  function automatic logic [`ZCMP_REG_W-1:0] map_sreg(input logic [2:0] f);
    map_sreg = {f[2:1] != 2'b00, f[2:1] == 2'b00, f};
  endfunction

  // quadrant 2, funct3 101 (no D extension)
  assign zcmp_space = (instr_i[1:0] == 2'b10) && (instr_i[15:13] == 3'b101);

  assign rlist = instr_i[7:4];
  assign spimm = instr_i[3:2];
  assign r1s   = instr_i[9:7];
  assign r2s   = instr_i[4:2];

  // rlist 15 saves s10 and s11 together
  assign n_regs = (rlist == 4'd15) ? 4'd13 : rlist - 4'd3;

  always_comb begin
    op_raw = OP_NONE;
    bad    = 1'b0;
    if (zcmp_space) begin
      if (instr_i[12:10] == 3'b011) begin
        unique case (instr_i[6:5])
          2'b01:   op_raw = OP_MVSA01;
          2'b11:   op_raw = OP_MVA01S;
          default: bad = 1'b1;
        endcase
        if (r1s == r2s) begin
          bad = 1'b1;  // both halves into one sreg
        end
      end else begin
        unique case (instr_i[12:8])
          5'b11000: op_raw = OP_PUSH;
          5'b11010: op_raw = OP_POP;
          5'b11100: op_raw = OP_POPRETZ;
          5'b11110: op_raw = OP_POPRET;
          default:  bad = 1'b1;
        endcase
        if (rlist < 4'd4) begin
          bad = 1'b1;  // reserved rlist
        end
      end
    end
  end

  assign illegal_o = bad;
  assign op_o      = bad ? OP_NONE : op_raw;

  // only the push/pop family walks a register list
  assign reg_cnt_o = (op_o == OP_PUSH || op_o == OP_POP ||
                      op_o == OP_POPRET || op_o == OP_POPRETZ) ? n_regs : '0;

  // list size rounded up to the alignment, plus the extra spimm frames
  assign list_bytes  = `ZCMP_IMM_W'(n_regs) * `ZCMP_IMM_W'(`ZCMP_REG_BYTES);
  assign stack_adj_o = ((list_bytes + ALIGN_MASK) & ~ALIGN_MASK) +
                       `ZCMP_IMM_W'(spimm) * `ZCMP_IMM_W'(`ZCMP_STACK_ALIGN);

  assign xreg1_o = map_sreg(r1s);
  assign xreg2_o = map_sreg(r2s);

endmodule

`default_nettype wire

/* hw/zcmp_macros.svh */
// widths, register numbers and stack sizes for the Zcmp expander; include before use
`ifndef ZCMP_MACROS_SVH
`define ZCMP_MACROS_SVH

// word and field widths
`define ZCMP_ILEN 32
`define ZCMP_IMM_W 12
`define ZCMP_REG_W 5
`define ZCMP_CNT_W 4

// RV32 stack frame
`define ZCMP_REG_BYTES 4     // one saved register
`define ZCMP_STACK_ALIGN 16

// architectural register numbers
`define ZCMP_REG_RA 1
`define ZCMP_REG_SP 2
`define ZCMP_REG_S0 8
`define ZCMP_REG_A0 10
`define ZCMP_REG_A1 11

`endif

/* hw/zcmp_pkg.sv */
// enum types shared by the Zcmp expander blocks; import inside the module body
`default_nettype none

package zcmp_pkg;

  // decoded Zcmp macro
  typedef enum logic [2:0] {
    OP_NONE,
    OP_PUSH,
    OP_POP,
    OP_POPRET,
    OP_POPRETZ,
    OP_MVSA01,
    OP_MVA01S
  } macro_op_e;

  // kind of plain RV32I micro-op to emit
  typedef enum logic [2:0] {
    UOP_PASS,    // input word unchanged
    UOP_STORE,
    UOP_LOAD,
    UOP_ADDI_SP,
    UOP_LI_ZERO,
    UOP_MOVE,
    UOP_RET
  } uop_kind_e;

  // sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SAVE_RESTORE,
    ST_ADJ_SP,
    ST_ZERO_A0,
    ST_RET,
    ST_MOVE2
  } seq_state_e;

  // major opcodes used by the micro-ops
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_JALR   = 7'b1100111
  } rv_opcode_e;

endpackage

`default_nettype wire

/* hw/zcmp_seq_fsm.sv */
// micro-op sequencer for one Zcmp macro; steps once per acknowledged micro-op
`timescale 1ns/1ps
`default_nettype none
`include "zcmp_macros.svh"

module zcmp_seq_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   instr_valid_i,
  input  logic                   issue_ack_i,
  input  zcmp_pkg::macro_op_e    op_i,
  input  logic [`ZCMP_CNT_W-1:0] reg_cnt_i,
  input  logic [`ZCMP_IMM_W-1:0] stack_adj_i,
  input  logic [`ZCMP_REG_W-1:0] xreg1_i,
  input  logic [`ZCMP_REG_W-1:0] xreg2_i,
  input  logic                   illegal_i,
  output zcmp_pkg::uop_kind_e    uop_kind_o,
  output logic [`ZCMP_REG_W-1:0] uop_rd_o,
  output logic [`ZCMP_REG_W-1:0] uop_rs_o,
  output logic [`ZCMP_IMM_W-1:0] uop_imm_o,
  output logic                   instr_valid_o,
  output logic                   instr_ready_o,
  output logic                   last_o,
  output logic                   illegal_o
);
  import zcmp_pkg::*;

  localparam logic [`ZCMP_IMM_W-1:0] REG_BYTES = `ZCMP_IMM_W'(`ZCMP_REG_BYTES);
  localparam logic [`ZCMP_REG_W-1:0] REG_RA = `ZCMP_REG_W'(`ZCMP_REG_RA);
  localparam logic [`ZCMP_REG_W-1:0] REG_SP = `ZCMP_REG_W'(`ZCMP_REG_SP);
  localparam logic [`ZCMP_REG_W-1:0] REG_S0 = `ZCMP_REG_W'(`ZCMP_REG_S0);
  localparam logic [`ZCMP_REG_W-1:0] REG_A0 = `ZCMP_REG_W'(`ZCMP_REG_A0);
  localparam logic [`ZCMP_REG_W-1:0] REG_A1 = `ZCMP_REG_W'(`ZCMP_REG_A1);
  localparam logic [`ZCMP_REG_W-1:0] REG_S2 = `ZCMP_REG_W'(18);

  seq_state_e             state_q, state_d, cur_st;
  logic [`ZCMP_CNT_W-1:0] idx_q, idx_d, cur_idx, list_pos;
  logic [`ZCMP_IMM_W-1:0] off_q, off_d, cur_off;
  logic [`ZCMP_REG_W-1:0] list_reg;
  logic                   is_push;
  logic                   is_ret;
  logic                   fire;
  logic                   is_last;

  assign is_push = (op_i == OP_PUSH);
  assign is_ret  = (op_i == OP_POPRET) || (op_i == OP_POPRETZ);
  assign fire    = instr_valid_i && issue_ack_i;

  // the first list entry (k = 1) is offered straight from idle
  always_comb begin
    cur_st  = state_q;
    cur_idx = idx_q;
    cur_off = off_q;
    if (state_q == ST_IDLE && reg_cnt_i != '0) begin
      cur_st  = ST_SAVE_RESTORE;
      cur_idx = `ZCMP_CNT_W'(1);
      cur_off = is_push ? ('0 - REG_BYTES) : (stack_adj_i - REG_BYTES);
    end
  end

  // list order is ra, s0, s1, s2..s11; entry k sits at position n-k
  assign list_pos = reg_cnt_i - cur_idx;

  always_comb begin
    unique case (list_pos)
      4'd0:    list_reg = REG_RA;
      4'd1:    list_reg = REG_S0;
      4'd2:    list_reg = REG_S0 + 5'd1;
      default: list_reg = REG_S2 + `ZCMP_REG_W'(list_pos - 4'd3);
    endcase
  end

  always_comb begin
    state_d    = state_q;
    idx_d      = idx_q;
    off_d      = off_q;
    uop_kind_o = UOP_PASS;
    uop_rd_o   = '0;
    uop_rs_o   = '0;
    uop_imm_o  = '0;
    is_last    = 1'b0;
    unique case (cur_st)
      ST_IDLE: begin
        if (op_i == OP_MVSA01 || op_i == OP_MVA01S) begin
          uop_kind_o = UOP_MOVE;  // a0 <-> xreg1
          uop_rd_o   = REG_A0;
          uop_rs_o   = xreg1_i;
          if (fire) state_d = ST_MOVE2;
        end else begin
          is_last = 1'b1;  // plain or illegal word
        end
      end
      ST_SAVE_RESTORE: begin
        uop_kind_o = is_push ? UOP_STORE : UOP_LOAD;
        uop_rd_o   = list_reg;
        uop_rs_o   = list_reg;
        uop_imm_o  = cur_off;
        if (fire) begin
          idx_d = cur_idx;
          if (cur_idx == reg_cnt_i) begin
            state_d = (op_i == OP_POPRETZ) ? ST_ZERO_A0 : ST_ADJ_SP;
          end else begin
            state_d = ST_SAVE_RESTORE;
            idx_d   = cur_idx + `ZCMP_CNT_W'(1);
            off_d   = cur_off - REG_BYTES;
          end
        end
      end
      ST_ZERO_A0: begin
        uop_kind_o = UOP_LI_ZERO;
        uop_rd_o   = REG_A0;
        if (fire) state_d = ST_ADJ_SP;
      end
      ST_ADJ_SP: begin
        uop_kind_o = UOP_ADDI_SP;
        uop_rd_o   = REG_SP;
        uop_rs_o   = REG_SP;
        uop_imm_o  = is_push ? ('0 - stack_adj_i) : stack_adj_i;
        is_last    = !is_ret;
        if (fire) state_d = is_ret ? ST_RET : ST_IDLE;
      end
      ST_RET: begin
        uop_kind_o = UOP_RET;
        uop_rs_o   = REG_RA;
        is_last    = 1'b1;
        if (fire) state_d = ST_IDLE;
      end
      ST_MOVE2: begin
        uop_kind_o = UOP_MOVE;  // a1 <-> xreg2
        uop_rd_o   = REG_A1;
        uop_rs_o   = xreg2_i;
        is_last    = 1'b1;
        if (fire) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
    if (state_d == ST_IDLE) idx_d = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  always_ff @(posedge clk_i) begin
    off_q <= off_d;
  end

  assign instr_valid_o = instr_valid_i;
  assign last_o        = instr_valid_i && is_last;
  assign instr_ready_o = last_o && issue_ack_i;
  assign illegal_o     = instr_valid_i && illegal_i && (state_q == ST_IDLE);

  // upstream must hold the word for the whole sequence
  a_busy_has_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != ST_IDLE) |-> instr_valid_i);

  a_idx_in_list: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idx_q <= reg_cnt_i);

endmodule

`default_nettype wire

/* hw/zcmp_uop_encode.sv */
// formats one sequencer micro-op as an RV32I word, or forwards the input word
`timescale 1ns/1ps
`default_nettype none
`include "zcmp_macros.svh"

module zcmp_uop_encode (
  input  logic [`ZCMP_ILEN-1:0]  instr_i,
  input  zcmp_pkg::uop_kind_e    uop_kind_i,
  input  logic [`ZCMP_REG_W-1:0] uop_rd_i,
  input  logic [`ZCMP_REG_W-1:0] uop_rs_i,
  input  logic [`ZCMP_IMM_W-1:0] uop_imm_i,
  input  zcmp_pkg::macro_op_e    op_i,
  output logic [`ZCMP_ILEN-1:0]  instr_o
);
  import zcmp_pkg::*;

  localparam logic [2:0] F3_WORD = 3'b010;  // lw / sw
  localparam logic [2:0] F3_ADDI = 3'b000;  // addi / jalr

  localparam logic [`ZCMP_REG_W-1:0] REG_X0 = '0;
  localparam logic [`ZCMP_REG_W-1:0] REG_SP = `ZCMP_REG_W'(`ZCMP_REG_SP);

  localparam logic [`ZCMP_IMM_W-1:0] IMM_ZERO = '0;

  always_comb begin
    unique case (uop_kind_i)
      // sw rs, imm(sp)
      UOP_STORE: begin
        instr_o = {uop_imm_i[11:5], uop_rs_i, REG_SP, F3_WORD, uop_imm_i[4:0], OPC_STORE};
      end
      // lw rd, imm(sp)
      UOP_LOAD: begin
        instr_o = {uop_imm_i, REG_SP, F3_WORD, uop_rd_i, OPC_LOAD};
      end
      UOP_ADDI_SP: begin
        instr_o = {uop_imm_i, uop_rs_i, F3_ADDI, uop_rd_i, OPC_OP_IMM};
      end
      // li a0, 0
      UOP_LI_ZERO: begin
        instr_o = {IMM_ZERO, REG_X0, F3_ADDI, uop_rd_i, OPC_OP_IMM};
      end
      UOP_MOVE: begin
        // rd carries the a-register, rs the s-register
        if (op_i == OP_MVSA01) begin
          instr_o = {IMM_ZERO, uop_rd_i, F3_ADDI, uop_rs_i, OPC_OP_IMM};
        end else begin
          instr_o = {IMM_ZERO, uop_rs_i, F3_ADDI, uop_rd_i, OPC_OP_IMM};
        end
      end
      // ret = jalr x0, 0(ra)
      UOP_RET: begin
        instr_o = {IMM_ZERO, uop_rs_i, F3_ADDI, REG_X0, OPC_JALR};
      end
      default: instr_o = instr_i;  // UOP_PASS
    endcase
  end

endmodule

`default_nettype wire

/* tests/tb_zcmp_expander.sv */
// testbench for the Zcmp expander; LCG stimulus with random issue stalls, checked by zcmp_checker
`timescale 1ns/1ps
`default_nettype none
`include "zcmp_macros.svh"

module tb_zcmp_expander;

  localparam int N_PASS      = 100;
  localparam int N_PUSH      = 48;  // rlist 4..15 x spimm 0..3
  localparam int N_POP_EACH  = 20;
  localparam int N_MOVE_EACH = 20;
  localparam int N_ILL_EACH  = 8;
  localparam int N_WORDS     = N_PASS + N_PUSH + 3 * N_POP_EACH + 2 * N_MOVE_EACH +
                               4 * N_ILL_EACH;
  localparam int TIMEOUT_CYCLES = N_WORDS * 17 + 50;

  localparam logic [4:0] SEL_PUSH    = 5'b11000;
  localparam logic [4:0] SEL_POP     = 5'b11010;
  localparam logic [4:0] SEL_POPRETZ = 5'b11100;
  localparam logic [4:0] SEL_POPRET  = 5'b11110;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic [`ZCMP_ILEN-1:0] instr_i;
  logic                  instr_valid_i;
  logic                  instr_ready_o;
  logic [`ZCMP_ILEN-1:0] instr_o;
  logic                  instr_valid_o;
  logic                  illegal_o;
  logic                  last_o;
  logic                  issue_ack_i;
  logic [31:0]           seed = 32'h1022;
  int                    words_sent = 0;
  int                    cycle_cnt = 0;
  int                    tb_errors = 0;
  int                    chk_errors;
  int                    chk_words;
  int                    chk_uops;

  always #10 clk_i = ~clk_i;

  zcmp_expander u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .illegal_o     (illegal_o),
    .last_o        (last_o),
    .issue_ack_i   (issue_ack_i)
  );

  zcmp_checker u_chk (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .issue_ack_i   (issue_ack_i),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .illegal_o     (illegal_o),
    .last_o        (last_o),
    .instr_ready_o (instr_ready_o),
    .err_cnt_o     (chk_errors),
    .words_done_o  (chk_words),
    .uops_done_o   (chk_uops)
  );

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] pass_word();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    a = lcg_next();
    b = lcg_next();
    w = {a[31:16], b[31:16]};
    if (w[1:0] == 2'b10 && w[15:13] == 3'b101) begin
      w[13] = 1'b0;  // step out of Zcmp space
    end
    return w;
  endfunction

  function automatic logic [31:0] stack_word(input logic [4:0] sel, input logic [3:0] rlist,
                                             input logic [1:0] spimm);
    return {16'h0000, 3'b101, sel, rlist, spimm, 2'b10};
  endfunction

  function automatic logic [31:0] move_word(input logic [2:0] r1, input logic [1:0] sel,
                                            input logic [2:0] r2);
    return {16'h0000, 3'b101, 3'b011, r1, sel, r2, 2'b10};
  endfunction

  function automatic logic [4:0] stack_sel(input logic [1:0] k);
    case (k)
      2'd0:    return SEL_PUSH;
      2'd1:    return SEL_POP;
      2'd2:    return SEL_POPRETZ;
      default: return SEL_POPRET;
    endcase
  endfunction

  function automatic logic [2:0] distinct_field(input logic [2:0] f, input logic [2:0] g);
    return (g == f) ? f + 3'd1 : g;
  endfunction

  // any Zcmp pattern in bits 12..8 that is neither a move nor a push/pop
  function automatic logic [31:0] reserved_word();
    logic [31:0] r;
    r = lcg_next();
    while (r[31:29] == 3'b011 || r[31:27] == SEL_PUSH || r[31:27] == SEL_POP ||
           r[31:27] == SEL_POPRETZ || r[31:27] == SEL_POPRET) begin
      r = lcg_next();
    end
    return stack_word(r[31:27], r[26:23], r[22:21]);
  endfunction

  // call on a rising edge; returns on the rising edge after the word is taken
  task automatic send_word(input logic [31:0] w);
    logic        accepted;
    logic [31:0] r;
    accepted = 1'b0;
    instr_i       <= w;
    instr_valid_i <= 1'b1;
    while (!accepted) begin
      r = lcg_next();
      issue_ack_i <= (r[31:30] != 2'b00);  // 75% acknowledge
      @(negedge clk_i);
      accepted = instr_ready_o;
      @(posedge clk_i);
    end
    words_sent++;
    r = lcg_next();
    if (r[31:29] == 3'b000) begin
      instr_valid_i <= 1'b0;  // occasional bubble
      issue_ack_i   <= r[28];
      @(posedge clk_i);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d words accepted",
               cycle_cnt, words_sent, N_WORDS);
      $display("Test failed");
      $finish;
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    int          i;
    int          s;
    int          rl;
    int          sp;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    issue_ack_i   = 1'b0;
    rst_ni        = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    for (i = 0; i < N_PASS; i++) begin
      send_word(pass_word());
    end
    for (rl = 4; rl < 16; rl++) begin
      for (sp = 0; sp < 4; sp++) begin
        send_word(stack_word(SEL_PUSH, 4'(rl), 2'(sp)));
      end
    end
    for (i = 0; i < N_POP_EACH; i++) begin
      for (s = 1; s < 4; s++) begin
        r = lcg_next();
        send_word(stack_word(stack_sel(s[1:0]), 4'(int'(r[23:16]) % 12 + 4), r[25:24]));
      end
    end
    for (i = 0; i < N_MOVE_EACH; i++) begin
      r = lcg_next();
      send_word(move_word(r[31:29], 2'b01, distinct_field(r[31:29], r[28:26])));
      r = lcg_next();
      send_word(move_word(r[31:29], 2'b11, distinct_field(r[31:29], r[28:26])));
    end
    for (i = 0; i < N_ILL_EACH; i++) begin
      r = lcg_next();
      send_word(move_word(r[31:29], {r[25], 1'b1}, r[31:29]));  // equal fields
      r = lcg_next();
      send_word(move_word(r[31:29], {r[25], 1'b0}, distinct_field(r[31:29], r[28:26])));
      send_word(reserved_word());
      r = lcg_next();
      send_word(stack_word(stack_sel(r[31:30]), {2'b00, r[29:28]}, r[27:26]));
    end

    instr_valid_i <= 1'b0;
    issue_ack_i   <= 1'b0;
    repeat (3) @(posedge clk_i);
    if (chk_words != N_WORDS || words_sent != N_WORDS) begin
      $display("Error: %0d words sent, %0d completed by the checker, %0d planned",
               words_sent, chk_words, N_WORDS);
      tb_errors++;
    end
    $display("errors %0d (checker %0d, testbench %0d), words %0d, micro-ops %0d",
             chk_errors + tb_errors, chk_errors, tb_errors, chk_words, chk_uops);
    if (chk_errors + tb_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/zcmp_checker.sv */
// reference model and scoreboard for the Zcmp expander; instantiated by the testbench
`timescale 1ns/1ps
`default_nettype none
`include "zcmp_macros.svh"

module zcmp_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`ZCMP_ILEN-1:0] instr_i,
  input  logic                  instr_valid_i,
  input  logic                  issue_ack_i,
  input  logic [`ZCMP_ILEN-1:0] instr_o,
  input  logic                  instr_valid_o,
  input  logic                  illegal_o,
  input  logic                  last_o,
  input  logic                  instr_ready_o,
  output int                    err_cnt_o,
  output int                    words_done_o,
  output int                    uops_done_o
);

  logic [31:0] exp_q[$];  // expected micro-ops of the current word
  logic        exp_ill = 1'b0;
  logic        busy = 1'b0;
  logic [31:0] cur_word = '0;
  string       test_name = "idle";
  int          errors = 0;
  int          words = 0;
  int          uops = 0;

  assign err_cnt_o    = errors;
  assign words_done_o = words;
  assign uops_done_o  = uops;

  function automatic logic [31:0] enc_itype(input int imm, input int rs1, input int rd,
                                            input logic [2:0] f3, input logic [6:0] opc);
    logic [11:0] imm12;
    imm12 = imm[11:0];
    return {imm12, rs1[4:0], f3, rd[4:0], opc};
  endfunction

  // sw rs2, imm(sp)
  function automatic logic [31:0] enc_sw(input int imm, input int rs2);
    logic [11:0] imm12;
    int          base;
    imm12 = imm[11:0];
    base  = `ZCMP_REG_SP;
    return {imm12[11:5], rs2[4:0], base[4:0], 3'b010, imm12[4:0], 7'b0100011};
  endfunction

  // ra, s0, s1, then s2..s11 = x18..x27
  function automatic int list_reg(input int pos);
    if (pos == 0) return `ZCMP_REG_RA;
    if (pos < 3) return `ZCMP_REG_S0 + pos - 1;
    return 15 + pos;
  endfunction

  function automatic int sreg_num(input logic [2:0] f);
    return (f < 3'd2) ? 8 + int'(f) : 16 + int'(f);
  endfunction

  task automatic build_expected(input logic [31:0] w);
    logic [4:0] sel;
    int         n;
    int         adj;
    int         k;
    logic       is_push;
    exp_q.delete();
    exp_ill = 1'b0;
    sel     = w[12:8];
    if (w[1:0] != 2'b10 || w[15:13] != 3'b101) begin
      test_name = "pass";
      exp_q.push_back(w);
    end else if (w[12:10] == 3'b011) begin
      if (w[9:7] == w[4:2] || !w[5]) begin
        test_name = "illegal";
        exp_ill   = 1'b1;
        exp_q.push_back(w);
      end else if (!w[6]) begin
        test_name = "mvsa01";  // s-regs take a0, a1
        exp_q.push_back(enc_itype(0, `ZCMP_REG_A0, sreg_num(w[9:7]), 3'b000, 7'b0010011));
        exp_q.push_back(enc_itype(0, `ZCMP_REG_A1, sreg_num(w[4:2]), 3'b000, 7'b0010011));
      end else begin
        test_name = "mva01s";
        exp_q.push_back(enc_itype(0, sreg_num(w[9:7]), `ZCMP_REG_A0, 3'b000, 7'b0010011));
        exp_q.push_back(enc_itype(0, sreg_num(w[4:2]), `ZCMP_REG_A1, 3'b000, 7'b0010011));
      end
    end else if (w[7:4] < 4'd4 || !(sel == 5'b11000 || sel == 5'b11010 ||
                                    sel == 5'b11100 || sel == 5'b11110)) begin
      test_name = "illegal";
      exp_ill   = 1'b1;
      exp_q.push_back(w);
    end else begin
      n       = (w[7:4] == 4'd15) ? 13 : int'(w[7:4]) - 3;
      adj     = ((n * 4 + 15) / 16) * 16 + int'(w[3:2]) * 16;
      is_push = (sel == 5'b11000);
      case (sel)
        5'b11000: test_name = "push";
        5'b11010: test_name = "pop";
        5'b11100: test_name = "popretz";
        default:  test_name = "popret";
      endcase
      for (k = 1; k <= n; k++) begin
        if (is_push) begin
          exp_q.push_back(enc_sw(-4 * k, list_reg(n - k)));
        end else begin
          exp_q.push_back(enc_itype(adj - 4 * k, `ZCMP_REG_SP, list_reg(n - k),
                                    3'b010, 7'b0000011));
        end
      end
      if (sel == 5'b11100) begin
        exp_q.push_back(enc_itype(0, 0, `ZCMP_REG_A0, 3'b000, 7'b0010011));  // li a0, 0
      end
      exp_q.push_back(enc_itype(is_push ? -adj : adj, `ZCMP_REG_SP, `ZCMP_REG_SP,
                                3'b000, 7'b0010011));
      if (sel == 5'b11100 || sel == 5'b11110) begin
        exp_q.push_back(enc_itype(0, `ZCMP_REG_RA, 0, 3'b000, 7'b1100111));
      end
    end
  endtask

  task automatic check_bit(input string name, input string sig, input logic exp_v,
                           input logic act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s: %s expected %b actual %b", name, sig, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input string sig, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s: %s expected %h actual %h", name, sig, exp_v, act_v);
      errors++;
    end
  endtask

  // sample mid-cycle, when inputs and outputs are settled
  always @(negedge clk_i) begin
    logic last_exp;
    if (rst_ni) begin
      if (instr_valid_i) begin
        if (!busy) begin
          build_expected(instr_i);
          cur_word = instr_i;
          busy     = 1'b1;
        end else if (instr_i !== cur_word) begin
          $display("Error: %s word %h was replaced by %h before its last micro-op",
                   test_name, cur_word, instr_i);
          errors++;
          build_expected(instr_i);  // resync on the new word
          cur_word = instr_i;
        end
        last_exp = (exp_q.size() == 1);
        check_bit(test_name, "instr_valid_o", 1'b1, instr_valid_o);
        check_bit(test_name, "last_o", last_exp, last_o);
        check_bit(test_name, "illegal_o", exp_ill, illegal_o);
        check_bit(test_name, "instr_ready_o", issue_ack_i && last_exp, instr_ready_o);
        if (issue_ack_i) begin
          check_word(test_name, "instr_o", exp_q[0], instr_o);
          void'(exp_q.pop_front());
          uops++;
          if (exp_q.size() == 0) begin
            busy = 1'b0;
            words++;
          end
        end
      end else begin
        if (busy) begin
          $display("Error: instr_valid_i dropped during a %s sequence", test_name);
          errors++;
          busy = 1'b0;
        end
        check_bit("idle", "instr_valid_o", 1'b0, instr_valid_o);
        check_bit("idle", "instr_ready_o", 1'b0, instr_ready_o);
        check_bit("idle", "last_o", 1'b0, last_o);
      end
    end
  end

endmodule

`default_nettype wire

/* zcmp_expander.f */
+incdir+hw
hw/zcmp_pkg.sv
hw/zcmp_field_decode.sv
hw/zcmp_seq_fsm.sv
hw/zcmp_uop_encode.sv
hw/zcmp_expander.sv
tests/zcmp_checker.sv
tests/tb_zcmp_expander.sv
